/* console_pkg.sv */
`default_nettype none

package console_pkg;

    // ##########################################################
    // widths
    // ##########################################################
    localparam int word_width  = 12;
    localparam int field_width = 3;
    localparam int state_width = 5;

    typedef logic [word_width-1:0]  word_t;   // machine word
    typedef logic [field_width-1:0] field_t;  // memory field
    typedef logic [state_width-1:0] major_state_t;

    // ##########################################################
    // console timing and storage
    // ##########################################################
    localparam int dbnce_nu_bits = 4;  // lockout counter is one bit wider
    localparam int sync_stages   = 2;
    localparam int mem_depth     = 256;
    localparam int mem_addr_bits = $clog2(mem_depth);

    // major states of the processor
    localparam major_state_t F0 = 5'h00;  // fetch
    localparam major_state_t F1 = 5'h01;
    localparam major_state_t F2 = 5'h02;
    localparam major_state_t F3 = 5'h03;
    localparam major_state_t D0 = 5'h08;  // defer
    localparam major_state_t D1 = 5'h09;
    localparam major_state_t E0 = 5'h10;  // execute
    localparam major_state_t E1 = 5'h11;
    localparam major_state_t H0 = 5'h1f;  // halted

    // front panel key levels, clear is the msb
    typedef struct packed {
        logic clear;
        logic extd_addr;
        logic addr_load;
        logic dep;
        logic exam;
        logic cont;
        logic sing_step;
        logic halt;
    } panel_switches_t;

endpackage

`default_nettype wire

/* panel_strobe_if.sv */
`timescale 1ns/1ps
`default_nettype none

// held key strobes from the trigger sequencer
interface panel_strobe_if;

    logic triggerd;    // high for the whole strobe window
    logic cleard;
    logic extd_addrd;
    logic addr_loadd;
    logic depd;
    logic examd;
    logic contd;

    modport sequencer (
        output triggerd,
        output cleard,
        output extd_addrd,
        output addr_loadd,
        output depd,
        output examd,
        output contd
    );

    modport executor (
        input triggerd,
        input cleard,
        input extd_addrd,
        input addr_loadd,
        input depd,
        input examd,
        input contd
    );

endinterface

`default_nettype wire

/* switch_sync.sv */
`timescale 1ns/1ps
`default_nettype none

// flop chain for asynchronous panel levels
module switch_sync #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire payload_t d,
    output payload_t      q
);

    // stage 0 may go metastable, later stages settle it
    payload_t stage [console_pkg::sync_stages];

    // ##########################################################
    // synchronizer chain
    // ##########################################################
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < console_pkg::sync_stages; i++)
            begin
                stage[i] <= '0;
            end
        end
        else
        begin
            stage[0] <= d;
            for (int i = 1; i < console_pkg::sync_stages; i++)
            begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[console_pkg::sync_stages-1];  // oldest sample

endmodule

`default_nettype wire

/* front_panel.sv */
`timescale 1ns/1ps
`default_nettype none

// trigger sequencer for the console keys
module front_panel (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire console_pkg::major_state_t    state,
    input  wire console_pkg::panel_switches_t switches,
    panel_strobe_if.sequencer                 strobes
);

    typedef enum logic [2:0] {
        st_wait,
        st_trig1,
        st_trig2,
        st_trig3,
        st_delay,
        st_reenable
    } trig_state_t;

    trig_state_t                         trig_state;
    logic [console_pkg::dbnce_nu_bits:0] trig_cnt;  // top bit ends lockout
    logic [6:0]                          strobe_q;
    logic                                any_key;
    logic                                cont_c;
    logic                                running;
    logic                                accept;

    assign {strobes.triggerd, strobes.cleard, strobes.extd_addrd, strobes.addr_loadd,
            strobes.depd, strobes.examd, strobes.contd} = strobe_q;

    // ##########################################################
    // press qualification
    // ##########################################################
    always_comb
    begin
        any_key = switches.clear | switches.extd_addr | switches.addr_load |
                  switches.dep | switches.exam | switches.cont;
        cont_c  = switches.cont & (switches.sing_step | switches.halt);
        running = (state == console_pkg::F0) || (state == console_pkg::D0) ||
                  (state == console_pkg::E0);
        accept  = 1'b0;
        if (trig_state == st_wait)
        begin
            if (state == console_pkg::H0)
                accept = any_key;
            else if (running)
                accept = cont_c;  // only stop requests while running
        end
    end

    // ##########################################################
    // sequencer and lockout counter
    // ##########################################################
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            trig_state <= st_wait;
            strobe_q   <= '0;
            trig_cnt   <= '0;
        end
        else
        begin
            case (trig_state)
                st_wait:
                begin
                    if (accept)
                    begin
                        trig_state <= st_trig1;
                        strobe_q   <= {1'b1, switches.clear, switches.extd_addr,
                                       switches.addr_load, switches.dep,
                                       switches.exam, switches.cont};
                    end
                end
                st_trig1: trig_state <= st_trig2;
                st_trig2: trig_state <= st_trig3;
                st_trig3: trig_state <= st_delay;
                st_delay:
                begin
                    strobe_q <= '0;  // fourth strobe cycle ends here
                    if (trig_cnt[console_pkg::dbnce_nu_bits])
                        trig_state <= st_reenable;
                end
                st_reenable: trig_state <= st_wait;
                default:     trig_state <= st_wait;
            endcase

            if (trig_state == st_trig1)
                trig_cnt <= '0;
            else
                trig_cnt <= trig_cnt + 1'b1;
        end
    end

    // executor samples keys at any point of the window
    keys_held: assert property (@(posedge clk) disable iff (reset)
        strobes.triggerd && $past(strobes.triggerd) |-> $stable(strobe_q[5:0]));

endmodule

`default_nettype wire

/* panel_executor.sv */
`timescale 1ns/1ps
`default_nettype none

// console action unit
module panel_executor (
    input  wire logic                clk,
    input  wire logic                reset,
    panel_strobe_if.executor         strobes,
    input  wire console_pkg::word_t  sr,
    input  wire logic                halt_key,
    output console_pkg::word_t       pc,
    output console_pkg::field_t      ifield,
    output console_pkg::field_t      dfield,
    output console_pkg::word_t       display,
    output logic                     cont_pulse,
    output logic                     run_request
);

    console_pkg::word_t mem [console_pkg::mem_depth] = '{default: '0};

    logic [console_pkg::mem_addr_bits-1:0] mem_addr;
    logic trig_q;
    logic act;     // one cycle per trigger
    logic sel_clear;
    logic sel_extd;
    logic sel_addr;
    logic sel_dep;
    logic sel_exam;
    logic sel_cont;

    assign mem_addr = pc[console_pkg::mem_addr_bits-1:0];  // pc mod depth

    // ##########################################################
    // trigger edge detect
    // ##########################################################
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            trig_q <= 1'b0;
            act    <= 1'b0;
        end
        else
        begin
            trig_q <= strobes.triggerd;
            act    <= strobes.triggerd & ~trig_q;
        end
    end

    // fixed priority, first key wins
    always_comb
    begin
        sel_clear = strobes.cleard;
        sel_extd  = ~sel_clear & strobes.extd_addrd;
        sel_addr  = ~strobes.cleard & ~strobes.extd_addrd & strobes.addr_loadd;
        sel_dep   = ~strobes.cleard & ~strobes.extd_addrd & ~strobes.addr_loadd &
                    strobes.depd;
        sel_exam  = ~strobes.cleard & ~strobes.extd_addrd & ~strobes.addr_loadd &
                    ~strobes.depd & strobes.examd;
        sel_cont  = ~strobes.cleard & ~strobes.extd_addrd & ~strobes.addr_loadd &
                    ~strobes.depd & ~strobes.examd & strobes.contd;
    end

    // ##########################################################
    // registers and display
    // ##########################################################
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc          <= '0;
            ifield      <= '0;
            dfield      <= '0;
            display     <= '0;
            cont_pulse  <= 1'b0;
            run_request <= 1'b0;
        end
        else
        begin
            cont_pulse <= 1'b0;
            if (act)
            begin
                if (sel_clear)
                begin
                    display <= '0;  // accumulator display
                end
                else if (sel_extd)
                begin
                    ifield <= sr[8:6];
                    dfield <= sr[5:3];
                end
                else if (sel_addr)
                begin
                    pc <= sr;
                end
                else if (sel_dep)
                begin
                    display <= sr;
                    pc      <= pc + 1'b1;
                end
                else if (sel_exam)
                begin
                    display <= mem[mem_addr];
                    pc      <= pc + 1'b1;
                end
                else if (sel_cont)
                begin
                    cont_pulse  <= 1'b1;
                    run_request <= ~halt_key;
                end
            end
        end
    end

    // console memory write port
    always_ff @(posedge clk)
    begin
        if (act && sel_dep)
            mem[mem_addr] <= sr;
    end

    cont_single: assert property (@(posedge clk) disable iff (reset)
        cont_pulse |=> !cont_pulse);

endmodule

`default_nettype wire

/* panel_console_top.sv */
`timescale 1ns/1ps
`default_nettype none

module panel_console_top (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire console_pkg::major_state_t    state,
    input  wire console_pkg::panel_switches_t switches,
    input  wire console_pkg::word_t           sr,
    output console_pkg::word_t                pc,
    output console_pkg::field_t               ifield,
    output console_pkg::field_t               dfield,
    output console_pkg::word_t                display,
    output logic                              cont_pulse,
    output logic                              run_request
);

    console_pkg::panel_switches_t switches_s;  // synchronized keys
    console_pkg::word_t           sr_s;
    logic                         halt_key;

    panel_strobe_if strobe_bus ();

    // ##########################################################
    // input side
    // ##########################################################
    switch_sync #(
        .payload_t (console_pkg::panel_switches_t)
    ) switch_sync_keys (
        .clk   (clk),
        .reset (reset),
        .d     (switches),
        .q     (switches_s)
    );

    switch_sync #(
        .payload_t (console_pkg::word_t)
    ) switch_sync_sr (
        .clk   (clk),
        .reset (reset),
        .d     (sr),
        .q     (sr_s)
    );

    front_panel front_panel_i (
        .clk      (clk),
        .reset    (reset),
        .state    (state),
        .switches (switches_s),
        .strobes  (strobe_bus.sequencer)
    );

    // single step stops again after one instruction
    assign halt_key = switches_s.halt | switches_s.sing_step;

    panel_executor panel_executor_i (
        .clk         (clk),
        .reset       (reset),
        .strobes     (strobe_bus.executor),
        .sr          (sr_s),
        .halt_key    (halt_key),
        .pc          (pc),
        .ifield      (ifield),
        .dfield      (dfield),
        .display     (display),
        .cont_pulse  (cont_pulse),
        .run_request (run_request)
    );

endmodule

`default_nettype wire

/* tb_panel_console.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_panel_console;

    // key bits in panel_switches_t order, clear is the msb
    localparam logic [7:0] k_clear = 8'h80;
    localparam logic [7:0] k_extd  = 8'h40;
    localparam logic [7:0] k_addr  = 8'h20;
    localparam logic [7:0] k_dep   = 8'h10;
    localparam logic [7:0] k_exam  = 8'h08;
    localparam logic [7:0] k_cont  = 8'h04;
    localparam logic [7:0] k_step  = 8'h02;
    localparam logic [7:0] k_halt  = 8'h01;

    localparam int lockout_gap = (1 << console_pkg::dbnce_nu_bits) + 8;  // lockout plus margin

    logic                         clk = 1'b0;
    logic                         reset;
    console_pkg::major_state_t    state;
    console_pkg::panel_switches_t switches;
    console_pkg::word_t           sr;
    console_pkg::word_t           pc;
    console_pkg::field_t          ifield;
    console_pkg::field_t          dfield;
    console_pkg::word_t           display;
    logic                         cont_pulse;
    logic                         run_request;

    // reference model
    console_pkg::word_t  exp_pc;
    console_pkg::field_t exp_ifield;
    console_pkg::field_t exp_dfield;
    console_pkg::word_t  exp_display;
    logic                exp_run;
    logic [11:0]         exp_pulses;
    console_pkg::word_t  model_mem [console_pkg::mem_depth];

    logic [11:0] pulse_count;
    logic [31:0] lfsr = 32'h96ea;
    int          req_count = 0;
    int          done_count = 0;
    int          pass_tests = 0;
    int          fail_tests = 0;
    string       test_name;
    console_pkg::word_t        start_addr;
    console_pkg::major_state_t run_states [3] = '{console_pkg::F0, console_pkg::D0,
                                                 console_pkg::E0};

    panel_console_top panel_console_top_i (
        .clk         (clk),
        .reset       (reset),
        .state       (state),
        .switches    (switches),
        .sr          (sr),
        .pc          (pc),
        .ifield      (ifield),
        .dfield      (dfield),
        .display     (display),
        .cont_pulse  (cont_pulse),
        .run_request (run_request)
    );

    always #5 clk = ~clk;

    // ##########################################################
    // random source and reference model
    // ##########################################################
    function automatic logic [31:0] lfsr_step(input logic [31:0] v);
        if (v[0])
            return (v >> 1) ^ 32'h8020_0003;
        else
            return v >> 1;
    endfunction

    function automatic logic [11:0] rand_bits(input int n);
        logic [11:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            r = {r[10:0], lfsr[0]};  // one step per bit
        end
        return r;
    endfunction

    function automatic void model_press(input console_pkg::major_state_t st,
                                        input logic [7:0] k, input console_pkg::word_t s);
        console_pkg::panel_switches_t kk;
        logic running;
        logic accepted;
        int   idx;
        kk       = k;
        running  = (st == console_pkg::F0) || (st == console_pkg::D0) ||
                   (st == console_pkg::E0);
        accepted = ((st == console_pkg::H0) && (kk.clear | kk.extd_addr | kk.addr_load |
                                                 kk.dep | kk.exam | kk.cont)) ||
                   (running && kk.cont && (kk.sing_step | kk.halt));
        idx      = int'(exp_pc) % console_pkg::mem_depth;
        if (accepted)
        begin
            if (kk.clear)
                exp_display = '0;
            else if (kk.extd_addr)
            begin
                exp_ifield = s[8:6];
                exp_dfield = s[5:3];
            end
            else if (kk.addr_load)
                exp_pc = s;
            else if (kk.dep)
            begin
                model_mem[idx] = s;
                exp_display    = s;
                exp_pc         = exp_pc + 12'd1;
            end
            else if (kk.exam)
            begin
                exp_display = model_mem[idx];
                exp_pc      = exp_pc + 12'd1;
            end
            else if (kk.cont)
            begin
                exp_pulses = exp_pulses + 12'd1;
                exp_run    = ~(kk.halt | kk.sing_step);
            end
        end
    endfunction

    // ##########################################################
    // comparing process
    // ##########################################################
    function automatic int check_value(input string name, input logic [11:0] got,
                                       input logic [11:0] exp);
        check_value = 0;
        assert (got === exp)
        else
        begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            check_value = 1;
        end
    endfunction

    always @(posedge clk)
    begin
        if (reset)
            pulse_count <= '0;
        else if (cont_pulse)
            pulse_count <= pulse_count + 12'd1;
    end

    always @(posedge clk)
    begin : compare_outputs
        int errs;
        if (done_count != req_count)
        begin
            errs = 0;
            errs += check_value("pc", pc, exp_pc);
            errs += check_value("ifield", {9'd0, ifield}, {9'd0, exp_ifield});
            errs += check_value("dfield", {9'd0, dfield}, {9'd0, exp_dfield});
            errs += check_value("display", display, exp_display);
            errs += check_value("run_request", {11'd0, run_request}, {11'd0, exp_run});
            errs += check_value("cont_pulse count", pulse_count, exp_pulses);
            if (errs == 0)
            begin
                pass_tests++;
                $display("test %0d %s: ok", done_count + 1, test_name);
            end
            else
            begin
                fail_tests++;
                $display("test %0d %s: FAILED, %0d wrong", done_count + 1, test_name, errs);
            end
            done_count <= done_count + 1;
        end
    end

    // ##########################################################
    // stimulus helpers
    // ##########################################################
    task automatic request_check(input string name);
        int guard;
        guard     = 0;
        test_name = name;
        req_count++;
        while (done_count != req_count && guard < 20)
        begin
            @(negedge clk);
            guard++;
        end
        if (done_count != req_count)
        begin
            $display("timeout: no comparison was made for %s", name);
            $display("Test failures found");
            $finish;
        end
    endtask

    task automatic press(input logic [7:0] k, input console_pkg::word_t s, input int gap);
        sr       = s;
        switches = k;
        repeat (3) @(negedge clk);  // key held 3 cycles
        switches = '0;
        for (int i = 0; i < gap; i++)
            @(negedge clk);
    endtask

    task automatic press_and_check(input string name, input console_pkg::major_state_t st,
                                   input logic [7:0] k, input console_pkg::word_t s);
        state = st;
        model_press(st, k, s);
        press(k, s, lockout_gap);
        request_check(name);
    endtask

    // ##########################################################
    // test sequence
    // ##########################################################
    initial
    begin
        reset       = 1'b1;
        state       = console_pkg::H0;
        switches    = '0;
        sr          = '0;
        exp_pc      = '0;
        exp_ifield  = '0;
        exp_dfield  = '0;
        exp_display = '0;
        exp_run     = 1'b0;
        exp_pulses  = '0;
        foreach (model_mem[i])
            model_mem[i] = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        request_check("reset values");

        // deposits then examines from the same start
        start_addr = rand_bits(12);
        press_and_check("address load", console_pkg::H0, k_addr, start_addr);
        for (int i = 0; i < 6; i++)
            press_and_check("deposit", console_pkg::H0, k_dep, rand_bits(12));
        press_and_check("address reload", console_pkg::H0, k_addr, start_addr);
        for (int i = 0; i < 6; i++)
            press_and_check("examine", console_pkg::H0, k_exam, rand_bits(12));

        press_and_check("extended address load", console_pkg::H0, k_extd, rand_bits(12));
        press_and_check("clear", console_pkg::H0, k_clear, rand_bits(12));

        // run request goes high here, so the stop requests below must lower it
        press_and_check("cont with no halt", console_pkg::H0, k_cont, rand_bits(12));

        foreach (run_states[i])
        begin
            press_and_check($sformatf("cont step, state %0h", run_states[i]), run_states[i],
                            k_cont | k_step, rand_bits(12));
            press_and_check($sformatf("cont halt, state %0h", run_states[i]), run_states[i],
                            k_cont | k_halt, rand_bits(12));
            press_and_check($sformatf("cont alone, state %0h", run_states[i]), run_states[i],
                            k_cont, rand_bits(12));
        end
        press_and_check("deposit while fetching", console_pkg::F0, k_dep, rand_bits(12));

        // second press lands in the lockout window
        state = console_pkg::H0;
        model_press(console_pkg::H0, k_addr, 12'h0a5);
        press(k_addr, 12'h0a5, 2);
        press(k_dep, 12'h5a3, lockout_gap);
        request_check("press during lockout");
        press_and_check("press after lockout", console_pkg::H0, k_dep, 12'h5a3);

        press_and_check("clear over dep and exam", console_pkg::H0,
                        k_clear | k_dep | k_exam, rand_bits(12));
        press_and_check("address load over dep", console_pkg::H0, k_addr | k_dep, rand_bits(12));
        for (int i = 0; i < 6; i++)
            press_and_check("random keys", console_pkg::H0, 8'(rand_bits(8)), rand_bits(12));

        $display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
        if (fail_tests == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
console_pkg.sv
panel_strobe_if.sv
switch_sync.sv
front_panel.sv
panel_executor.sv
panel_console_top.sv
tb_panel_console.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_panel_console -f filelist.f -o sim_panel
	./obj_dir/sim_panel | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
